/* build.f */
logic/corr_pkg.sv
logic/corr_unit.sv
logic/vis_bank.sv
logic/corr_bus_arbiter.sv
logic/corr_block.sv
verif/corr_block_props.sv
verif/tb_corr_block.sv

/* logic/corr_block.sv */
`timescale 1ns/1ps

module corr_block import corr_pkg::*; #(
   parameter int                       ACCUM  = ACCUM_DEF,
   // Pair 0 in the low 16 bits, {A, B} per pair
   parameter logic [NPAIRS*PAIR_W-1:0] PAIRS0 = 64'h0607_0405_0203_0001,
   parameter logic [NPAIRS*PAIR_W-1:0] PAIRS1 = 64'h0c0d_0a0b_0109_0008,
   parameter logic [NPAIRS*PAIR_W-1:0] PAIRS2 = 64'h1415_1213_1011_0e0f,
   parameter logic [NPAIRS*PAIR_W-1:0] PAIRS3 = 64'h0303_0511_0017_1617
) (
   input  logic              clk_i,
   input  logic              rst,
   // Read bus
   input  logic              cyc_i,
   input  logic              stb_i,
   input  logic              we_i,
   input  logic [ABITS-1:0]  adr_i,
   output logic              ack_o,
   output logic [ACCUM-1:0]  dat_o,
   // Antenna samples
   input  logic              en_i,
   input  logic              sw_i,
   input  logic [NANT-1:0]   re_i,
   input  logic [NANT-1:0]   im_i,
   output logic              overflow_cos_o,
   output logic              overflow_sin_o
);

   localparam int PW = NPAIRS * PAIR_W;  // One unit's pair list
   localparam logic [NUNITS*PW-1:0] PAIRS_ALL = {PAIRS3, PAIRS2, PAIRS1, PAIRS0};

   logic [NUNITS*ACCUM-1:0] rd_dat;
   logic [VIS_SEL_W-1:0]    rd_adr;
   logic [NUNITS-1:0]       ovf_cos;
   logic [NUNITS-1:0]       ovf_sin;

   // --------------------
   // Units and their banks
   // --------------------
   for (genvar u = 0; u < NUNITS; u++) begin : g_unit
      logic                    acc_en;
      logic                    first;
      logic [NPAIRS*INC_W-1:0] cos_inc;
      logic [NPAIRS*INC_W-1:0] sin_inc;
      logic [NPAIRS*ACCUM-1:0] cur_cos;
      logic [NPAIRS*ACCUM-1:0] cur_sin;

      corr_unit #(
         .ACCUM (ACCUM),
         .PAIRS (PAIRS_ALL[u*PW +: PW])
      ) i_corr_unit (
         .clk_i     (clk_i),
         .rst       (rst),
         .en_i      (en_i),
         .sw_i      (sw_i),
         .re_i      (re_i),
         .im_i      (im_i),
         .cur_cos_i (cur_cos),
         .cur_sin_i (cur_sin),
         .acc_en_o  (acc_en),
         .first_o   (first),
         .cos_inc_o (cos_inc),
         .sin_inc_o (sin_inc),
         .ovf_cos_o (ovf_cos[u]),
         .ovf_sin_o (ovf_sin[u])
      );

      vis_bank #(
         .ACCUM (ACCUM)
      ) i_vis_bank (
         .clk_i     (clk_i),
         .rst       (rst),
         .sw_i      (sw_i),
         .acc_en_i  (acc_en),
         .first_i   (first),
         .cos_inc_i (cos_inc),
         .sin_inc_i (sin_inc),
         .rd_adr_i  (rd_adr),
         .cur_cos_o (cur_cos),
         .cur_sin_o (cur_sin),
         .rd_dat_o  (rd_dat[u*ACCUM +: ACCUM])
      );
   end

   // --------------------
   // Shared read bus
   // --------------------
   corr_bus_arbiter #(
      .ACCUM (ACCUM)
   ) i_corr_bus_arbiter (
      .clk_i    (clk_i),
      .rst      (rst),
      .cyc_i    (cyc_i),
      .stb_i    (stb_i),
      .we_i     (we_i),
      .adr_i    (adr_i),
      .rd_dat_i (rd_dat),
      .rd_adr_o (rd_adr),
      .ack_o    (ack_o),
      .dat_o    (dat_o)
   );

   assign overflow_cos_o = |ovf_cos;  // Any unit wrapped
   assign overflow_sin_o = |ovf_sin;

endmodule

/* logic/corr_bus_arbiter.sv */
`timescale 1ns/1ps

module corr_bus_arbiter import corr_pkg::*; #(
   parameter int ACCUM = ACCUM_DEF
) (
   input  logic                      clk_i,
   input  logic                      rst,
   input  logic                      cyc_i,
   input  logic                      stb_i,
   input  logic                      we_i,     // Writes acked, no effect
   input  logic [ABITS-1:0]          adr_i,
   input  logic [NUNITS*ACCUM-1:0]   rd_dat_i, // One word per unit
   output logic [VIS_SEL_W-1:0]      rd_adr_o, // Shared by all banks
   output logic                      ack_o,
   output logic [ACCUM-1:0]          dat_o
);

   logic                 stb_q;
   logic                 we_q;
   logic [NUNITS-1:0]    unit_dec;  // One-hot unit select
   logic [NUNITS-1:0]    sel_q;
   logic [VIS_SEL_W-1:0] word_q;
   logic [ACCUM-1:0]     dat_sel;

   // --------------------
   // Address decode
   // --------------------
   always_comb begin
      unit_dec = '0;
      unit_dec[adr_i[ABITS-1 -: UNIT_SEL_W]] = 1'b1;
   end

   always_ff @(posedge clk_i) begin
      if (rst) begin
         stb_q <= 1'b0;
      end else begin
         stb_q <= stb_i & cyc_i;  // Only a strobe inside a cycle counts
      end
   end

   // Captured every cycle, held strobe streams one word per cycle
   always_ff @(posedge clk_i) begin
      sel_q  <= unit_dec;
      word_q <= adr_i[VIS_SEL_W-1:0];
      we_q   <= we_i;
   end

   assign rd_adr_o = word_q;

   // --------------------
   // Return multiplexer
   // --------------------
   always_comb begin
      dat_sel = '0;
      for (int u = 0; u < NUNITS; u++) begin
         if (sel_q[u]) begin
            dat_sel = dat_sel | rd_dat_i[u*ACCUM +: ACCUM];
         end
      end
   end

   assign ack_o = cyc_i & stb_q;            // Dropped cycle aborts the ack
   assign dat_o = we_q ? '0 : dat_sel;      // Nothing to return on a write

endmodule

/* logic/corr_pkg.sv */
package corr_pkg;

   // --------------------
   // Array geometry
   // --------------------
   localparam int NANT   = 24;  // Antennas, one sign bit each for re and im
   localparam int NUNITS = 4;   // Correlator units sharing the bus
   localparam int NPAIRS = 4;   // Antenna pairs per unit

   // Pair descriptor, antenna A in high byte and antenna B in low byte
   localparam int PAIR_W = 16;
   localparam int ANT_W  = PAIR_W / 2;

   // --------------------
   // Read bus address
   // --------------------
   // adr = {unit, pair, component}
   localparam int UNIT_SEL_W = 2;  // Top bits, unit select
   localparam int VIS_SEL_W  = 3;  // Pair index plus cos/sin bit
   localparam int ABITS      = UNIT_SEL_W + VIS_SEL_W;

   // --------------------
   // Arithmetic
   // --------------------
   localparam int ACCUM_DEF = 24;  // Default accumulator width
   localparam int INC_W     = 3;   // Per-sample increment, -2 .. +2

endpackage

/* logic/corr_unit.sv */
`timescale 1ns/1ps

module corr_unit import corr_pkg::*; #(
   parameter int                         ACCUM = ACCUM_DEF,
   parameter logic [NPAIRS*PAIR_W-1:0]   PAIRS = '0
) (
   input  logic                      clk_i,
   input  logic                      rst,
   input  logic                      en_i,      // Sample valid
   input  logic                      sw_i,      // Bank switch pulse
   input  logic [NANT-1:0]           re_i,
   input  logic [NANT-1:0]           im_i,
   input  logic [NPAIRS*ACCUM-1:0]   cur_cos_i, // Active bank contents
   input  logic [NPAIRS*ACCUM-1:0]   cur_sin_i,
   output logic                      acc_en_o,
   output logic                      first_o,
   output logic [NPAIRS*INC_W-1:0]   cos_inc_o,
   output logic [NPAIRS*INC_W-1:0]   sin_inc_o,
   output logic                      ovf_cos_o,
   output logic                      ovf_sin_o
);

   // Sign-bit product, equal bits give +1
   function automatic logic signed [INC_W-1:0] sgn_mul(input logic x, input logic y);
      logic signed [INC_W-1:0] res;
      res = (x == y) ? {{(INC_W-1){1'b0}}, 1'b1} : {INC_W{1'b1}};
      return res;
   endfunction

   logic              first_q;  // Active bank not yet written
   logic              ovf_cos_q;
   logic              ovf_sin_q;
   logic [NPAIRS-1:0] wrap_cos; // Per-pair wrap on this sample
   logic [NPAIRS-1:0] wrap_sin;

   assign acc_en_o = en_i;
   // Sample in the switch cycle already lands in the new bank
   assign first_o  = first_q | sw_i;

   // --------------------
   // Per-pair increments
   // --------------------
   for (genvar p = 0; p < NPAIRS; p++) begin : g_pair
      localparam int ANT_A = int'(PAIRS[p*PAIR_W + ANT_W +: ANT_W]);
      localparam int ANT_B = int'(PAIRS[p*PAIR_W +: ANT_W]);

      logic signed [INC_W-1:0] cos_inc;
      logic signed [INC_W-1:0] sin_inc;
      logic        [ACCUM-1:0] cur_cos;
      logic        [ACCUM-1:0] cur_sin;
      logic        [ACCUM-1:0] sum_cos;
      logic        [ACCUM-1:0] sum_sin;

      // cos = re*re + im*im
      assign cos_inc = sgn_mul(re_i[ANT_A], re_i[ANT_B]) + sgn_mul(im_i[ANT_A], im_i[ANT_B]);
      // sin = im_a*re_b - re_a*im_b
      assign sin_inc = sgn_mul(im_i[ANT_A], re_i[ANT_B]) - sgn_mul(re_i[ANT_A], im_i[ANT_B]);

      assign cos_inc_o[p*INC_W +: INC_W] = cos_inc;
      assign sin_inc_o[p*INC_W +: INC_W] = sin_inc;

      assign cur_cos = cur_cos_i[p*ACCUM +: ACCUM];
      assign cur_sin = cur_sin_i[p*ACCUM +: ACCUM];
      assign sum_cos = cur_cos + {{(ACCUM-INC_W){cos_inc[INC_W-1]}}, cos_inc};
      assign sum_sin = cur_sin + {{(ACCUM-INC_W){sin_inc[INC_W-1]}}, sin_inc};

      // Same-sign operands, sum sign flipped
      // Never on a first sample, base is zero then
      assign wrap_cos[p] = !first_o && (cur_cos[ACCUM-1] == cos_inc[INC_W-1])
                           && (sum_cos[ACCUM-1] != cur_cos[ACCUM-1]);
      assign wrap_sin[p] = !first_o && (cur_sin[ACCUM-1] == sin_inc[INC_W-1])
                           && (sum_sin[ACCUM-1] != cur_sin[ACCUM-1]);
   end

   // --------------------
   // First flag, sticky overflow
   // --------------------
   always_ff @(posedge clk_i) begin
      if (rst) begin
         first_q   <= 1'b1;  // Bank 0 starts empty
         ovf_cos_q <= 1'b0;
         ovf_sin_q <= 1'b0;
      end else begin
         if (en_i) begin
            first_q <= 1'b0;  // Also covers en with sw
         end else if (sw_i) begin
            first_q <= 1'b1;  // Lazy clear pending
         end

         if (sw_i) begin
            ovf_cos_q <= 1'b0;  // New period
            ovf_sin_q <= 1'b0;
         end else if (en_i) begin
            ovf_cos_q <= ovf_cos_q | (|wrap_cos);
            ovf_sin_q <= ovf_sin_q | (|wrap_sin);
         end
      end
   end

   assign ovf_cos_o = ovf_cos_q;
   assign ovf_sin_o = ovf_sin_q;

endmodule

/* logic/vis_bank.sv */
`timescale 1ns/1ps

module vis_bank import corr_pkg::*; #(
   parameter int ACCUM = ACCUM_DEF
) (
   input  logic                      clk_i,
   input  logic                      rst,
   input  logic                      sw_i,
   input  logic                      acc_en_i,
   input  logic                      first_i,    // Add to zero
   input  logic [NPAIRS*INC_W-1:0]   cos_inc_i,
   input  logic [NPAIRS*INC_W-1:0]   sin_inc_i,
   input  logic [VIS_SEL_W-1:0]      rd_adr_i,   // {pair, sin}
   output logic [NPAIRS*ACCUM-1:0]   cur_cos_o,
   output logic [NPAIRS*ACCUM-1:0]   cur_sin_o,
   output logic [ACCUM-1:0]          rd_dat_o
);

   logic             act_q;     // Active bank index
   logic [1:0]       empty_q;   // Bank holds no sample of its period
   logic             wr_bank;
   logic             rd_bank;
   logic [ACCUM-1:0] rd_cos [NPAIRS];
   logic [ACCUM-1:0] rd_sin [NPAIRS];

   // Switch takes effect on the same edge
   assign wr_bank = sw_i ? ~act_q : act_q;
   assign rd_bank = ~act_q;

   // --------------------
   // Accumulators, two banks per pair
   // --------------------
   for (genvar p = 0; p < NPAIRS; p++) begin : g_pair
      logic [ACCUM-1:0] cos_mem [2];
      logic [ACCUM-1:0] sin_mem [2];
      logic [ACCUM-1:0] cos_base;
      logic [ACCUM-1:0] sin_base;
      logic [INC_W-1:0] cos_inc;
      logic [INC_W-1:0] sin_inc;

      assign cos_inc = cos_inc_i[p*INC_W +: INC_W];
      assign sin_inc = sin_inc_i[p*INC_W +: INC_W];

      assign cur_cos_o[p*ACCUM +: ACCUM] = cos_mem[wr_bank];
      assign cur_sin_o[p*ACCUM +: ACCUM] = sin_mem[wr_bank];

      assign cos_base = first_i ? '0 : cos_mem[wr_bank];  // Lazy clear
      assign sin_base = first_i ? '0 : sin_mem[wr_bank];

      always_ff @(posedge clk_i) begin
         if (acc_en_i) begin
            cos_mem[wr_bank] <= cos_base + {{(ACCUM-INC_W){cos_inc[INC_W-1]}}, cos_inc};
            sin_mem[wr_bank] <= sin_base + {{(ACCUM-INC_W){sin_inc[INC_W-1]}}, sin_inc};
         end
      end

      assign rd_cos[p] = cos_mem[rd_bank];  // Inactive side only
      assign rd_sin[p] = sin_mem[rd_bank];
   end

   // --------------------
   // Bank pointer
   // --------------------
   always_ff @(posedge clk_i) begin
      if (rst) begin
         act_q   <= 1'b0;
         empty_q <= 2'b11;  // Both banks read zero
      end else begin
         act_q <= wr_bank;
         if (sw_i) begin
            empty_q[wr_bank] <= 1'b1;
         end
         if (acc_en_i) begin
            empty_q[wr_bank] <= 1'b0;  // Wins over the switch
         end
      end
   end

   // Empty period reads as zero
   assign rd_dat_o = empty_q[rd_bank] ? '0 :
                     rd_adr_i[0]      ? rd_sin[rd_adr_i[VIS_SEL_W-1:1]] :
                                        rd_cos[rd_adr_i[VIS_SEL_W-1:1]];

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_corr_block -Mdir obj_dir
./obj_dir/Vtb_corr_block | tee sim.log

if grep -q "Result: FAILED" sim.log; then
   exit 1
fi
# An aborted run leaves no result line at all
grep -q "Result: PASSED" sim.log

/* verif/corr_block_props.sv */
`timescale 1ns/1ps

module corr_block_props (
   input logic clk_i,
   input logic rst,
   input logic cyc_i,
   input logic stb_i,
   input logic ack_o,
   input logic sw_i,
   input logic overflow_cos_o,
   input logic overflow_sin_o
);

   // --------------------
   // Read bus
   // --------------------
   // Ack only for a strobe sampled inside a cycle, cycle still open
   ack_after_stb: assert property (@(posedge clk_i) disable iff (rst)
      ack_o |-> cyc_i && $past(stb_i && cyc_i))
      else $error("ack_o without a strobe sampled in the previous cycle");

   ack_needs_cyc: assert property (@(posedge clk_i) disable iff (rst)
      !cyc_i |-> !ack_o)
      else $error("ack_o high while cyc_i is low");

   // --------------------
   // Overflow flags
   // --------------------
   ovf_clear_on_sw: assert property (@(posedge clk_i) disable iff (rst)
      $past(sw_i) |-> !overflow_cos_o && !overflow_sin_o)
      else $error("overflow flag still set after a bank switch");

endmodule

bind corr_block corr_block_props i_corr_block_props (
   .clk_i          (clk_i),
   .rst            (rst),
   .cyc_i          (cyc_i),
   .stb_i          (stb_i),
   .ack_o          (ack_o),
   .sw_i           (sw_i),
   .overflow_cos_o (overflow_cos_o),
   .overflow_sin_o (overflow_sin_o)
);

/* verif/tb_corr_block.sv */
`timescale 1ns/1ps

module tb_corr_block import corr_pkg::*; ();

   localparam int ACCUM       = 10;  // Narrow, overflow within a few hundred samples
   localparam int CLK_PERIOD  = 20;
   localparam int ACK_TIMEOUT = 8;   // Cycles
   localparam int NADR        = 1 << ABITS;
   localparam int LIMIT       = 2**(ACCUM-1) - 1;
   localparam int OVF_SAMPLES = 300;
   // Antenna pairs, index unit*NPAIRS + pair
   localparam int PAIR_A [NUNITS*NPAIRS] = '{0, 2, 4, 6, 0, 1, 10, 12, 14, 16, 18, 20, 22, 0, 5, 3};
   localparam int PAIR_B [NUNITS*NPAIRS] = '{1, 3, 5, 7, 8, 9, 11, 13, 15, 17, 19, 21, 23, 23, 17, 3};

   logic             clk_i;
   logic             rst;
   logic             cyc_i;
   logic             stb_i;
   logic             we_i;
   logic [ABITS-1:0] adr_i;
   logic             ack_o;
   logic [ACCUM-1:0] dat_o;
   logic             en_i;
   logic             sw_i;
   logic [NANT-1:0]  re_i;
   logic [NANT-1:0]  im_i;
   logic             overflow_cos_o;
   logic             overflow_sin_o;

   integer           seed;
   int               checks;
   int               errors;
   int               test_base;
   logic [NANT-1:0]  cur_re [$];   // Samples of the running period
   logic [NANT-1:0]  cur_im [$];
   logic [NANT-1:0]  done_re [$];  // Last finished period, readable side
   logic [NANT-1:0]  done_im [$];

   corr_block #(.ACCUM(ACCUM)) i_corr_block (.*);

   always #(CLK_PERIOD/2) clk_i = ~clk_i;

   // --------------------
   // Reference model
   // --------------------
   function automatic int sign_product(input logic x, input logic y);
      return (x == y) ? 1 : -1;  // Bit 1 is +1, bit 0 is -1
   endfunction

   function automatic int pair_increment(input logic [NANT-1:0] re, input logic [NANT-1:0] im,
                                         input int idx, input logic sin);
      int a;
      int b;
      a = PAIR_A[idx];
      b = PAIR_B[idx];
      if (sin) return sign_product(im[a], re[b]) - sign_product(re[a], im[b]);
      return sign_product(re[a], re[b]) + sign_product(im[a], im[b]);
   endfunction

   // Expected word at adr, wrapped like the hardware
   function automatic logic [ACCUM-1:0] ref_value(input logic [ABITS-1:0] adr);
      int acc;
      int i;
      acc = 0;
      for (i = 0; i < done_re.size(); i++) begin
         acc += pair_increment(done_re[i], done_im[i], int'(adr[ABITS-1:1]), adr[0]);
      end
      return acc[ACCUM-1:0];
   endfunction

   // --------------------
   // Stimulus
   // --------------------
   task automatic drive_cycle(input logic en, input logic sw,
                              input logic [NANT-1:0] re, input logic [NANT-1:0] im);
      en_i = en;
      sw_i = sw;
      re_i = re;
      im_i = im;
      if (sw) begin  // Period ends here
         done_re = cur_re;
         done_im = cur_im;
         cur_re.delete();
         cur_im.delete();
      end
      if (en) begin  // With sw this opens the new period
         cur_re.push_back(re);
         cur_im.push_back(im);
      end
   endtask

   task automatic random_cycle(input logic en, input logic sw);
      logic [31:0] r_re;
      logic [31:0] r_im;
      r_re = $random(seed);
      r_im = $random(seed);
      @(negedge clk_i);
      drive_cycle(en, sw, r_re[NANT-1:0], r_im[NANT-1:0]);
   endtask

   task automatic switch_banks(input logic en);
      random_cycle(en, 1'b1);
      random_cycle(1'b0, 1'b0);
   endtask

   // --------------------
   // Checks
   // --------------------
   task automatic check_bit(input logic got, input logic exp, input string what);
      checks++;
      assert (got === exp) else begin
         $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_data(input logic [ABITS-1:0] adr);
      logic [ACCUM-1:0] exp;
      exp = ref_value(adr);
      checks++;
      assert (dat_o === exp) else begin
         $display("CHECK FAILED at %0t: address %0d read %0d, expected %0d",
                  $time, adr, dat_o, exp);
         errors++;
      end
   endtask

   // Single strobe, wait for ack, read data compared
   task automatic bus_access(input logic [ABITS-1:0] adr, input logic we);
      int waited;
      logic got;
      @(negedge clk_i);
      cyc_i  = 1'b1;
      stb_i  = 1'b1;
      we_i   = we;
      adr_i  = adr;
      got    = 1'b0;
      waited = 0;
      while (!got && waited < ACK_TIMEOUT) begin
         @(negedge clk_i);
         waited++;
         got = ack_o;
      end
      if (!got) begin
         $display("Access to address %0d at %0t got no ack within %0d cycles",
                  adr, $time, ACK_TIMEOUT);
         errors++;
      end else if (!we) begin
         check_data(adr);
      end
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
   endtask

   task automatic read_all();
      int a;
      for (a = 0; a < NADR; a++) begin
         bus_access(a[ABITS-1:0], 1'b0);
      end
   endtask

   // Held strobe, one ack per cycle for the previous address
   task automatic burst_check();
      int k;
      @(negedge clk_i);
      check_bit(ack_o, 1'b0, "ack_o before strobe");
      cyc_i = 1'b1;
      stb_i = 1'b1;
      adr_i = '0;
      for (k = 1; k <= NADR; k++) begin
         @(negedge clk_i);
         check_bit(ack_o, 1'b1, "ack_o one cycle after strobe");
         check_data(adr_i);
         adr_i = k[ABITS-1:0];
      end
      stb_i = 1'b0;
      cyc_i = 1'b0;
      @(negedge clk_i);
      stb_i = 1'b1;  // Strobe outside a cycle
      @(negedge clk_i);
      check_bit(ack_o, 1'b0, "ack_o with cyc_i low");
      stb_i = 1'b0;
   endtask

   task automatic end_test(input string name);
      if (errors == test_base) $display("Test %s: ok", name);
      else $display("Test %s: %0d errors", name, errors - test_base);
      test_base = errors;
   endtask

   // --------------------
   // Test sequence
   // --------------------
   initial begin
      int  k;
      int  run;
      logic ovf_exp;
      logic [31:0] r;
      clk_i = 1'b0;
      rst   = 1'b1;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
      adr_i = '0;
      en_i  = 1'b0;
      sw_i  = 1'b0;
      re_i  = '0;
      im_i  = '0;
      seed  = 32'h417c;
      checks    = 0;
      errors    = 0;
      test_base = 0;
      repeat (4) @(negedge clk_i);
      rst = 1'b0;

      @(negedge clk_i);
      check_bit(ack_o, 1'b0, "ack_o after reset");
      check_bit(overflow_cos_o, 1'b0, "overflow_cos_o after reset");
      check_bit(overflow_sin_o, 1'b0, "overflow_sin_o after reset");
      read_all();
      end_test("reset state");

      for (k = 0; k < 40; k++) begin
         random_cycle(1'b1, 1'b0);
         r = $random(seed);
         if (r[1:0] == 2'b00) random_cycle(1'b0, 1'b0);  // Ignored sample
      end
      switch_banks(1'b1);  // Sample with the switch, first of period two
      read_all();
      end_test("accumulation");

      for (k = 0; k < 24; k++) begin
         random_cycle(1'b1, 1'b0);
         r = $random(seed);
         if (r[1:0] == 2'b00) random_cycle(1'b0, 1'b0);
      end
      switch_banks(1'b1);  // Sample with the switch lands on the bank of period one
      read_all();
      end_test("lazy clear");

      fork
         begin
            repeat (30) random_cycle(1'b1, 1'b0);
            random_cycle(1'b0, 1'b0);
         end
         for (k = 0; k < NADR; k++) begin
            if (k % 8 == 3) bus_access(k[ABITS-1:0], 1'b1);  // Write, ignored
            bus_access(k[ABITS-1:0], 1'b0);
         end
      join
      switch_banks(1'b0);
      read_all();
      end_test("reads during accumulation");

      burst_check();
      end_test("bus timing");

      // All ones, every pair adds +2 to cos
      run     = 0;
      ovf_exp = 1'b0;
      for (k = 0; k < OVF_SAMPLES; k++) begin
         @(negedge clk_i);
         check_bit(overflow_cos_o, ovf_exp, "overflow_cos_o");
         check_bit(overflow_sin_o, 1'b0, "overflow_sin_o");
         drive_cycle(1'b1, 1'b0, '1, '1);
         run += pair_increment('1, '1, 0, 1'b0);
         if (run > LIMIT || run < -LIMIT - 1) ovf_exp = 1'b1;
      end
      @(negedge clk_i);
      check_bit(overflow_cos_o, ovf_exp, "overflow_cos_o at end of period");
      drive_cycle(1'b0, 1'b1, '0, '0);
      @(negedge clk_i);
      check_bit(overflow_cos_o, 1'b0, "overflow_cos_o after switch");
      drive_cycle(1'b0, 1'b0, '0, '0);
      read_all();
      end_test("overflow");

      $display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule
